// ==== common/if_pkg.sv ====
// rv32 fetch types only; every instruction is 32 bit and word aligned, no compressed support
package if_pkg;

  //////////////////////////////////////////////////
  // widths and fixed offsets
  //////////////////////////////////////////////////

  localparam int unsigned xlen        = 32;            // instr and address width
  localparam logic [31:0] boot_offset = 32'h0000_0080; // first fetch above boot base

  //////////////////////////////////////////////////
  // redirect selection
  //////////////////////////////////////////////////

  // redirect source seen by the pc mux
  typedef enum logic [2:0] {
    pc_boot = 3'd0,  // reset / boot address
    pc_jump = 3'd1,  // jump or taken branch from ex
    pc_exc  = 3'd2,  // exception, irq or debug entry
    pc_eret = 3'd3,  // mret, back to mepc
    pc_dret = 3'd4   // dret, back to depc
  } pc_sel_e;

  // which target to use when pc_mux selects pc_exc
  typedef enum logic [1:0] {
    exc_pc_exc     = 2'd0,  // synchronous exception, mtvec base
    exc_pc_irq     = 2'd1,  // vectored irq
    exc_pc_dbd     = 2'd2,  // debug halt
    exc_pc_dbg_exc = 2'd3   // exception while in debug mode
  } exc_pc_sel_e;

  // cause info for vectored irqs
  typedef struct packed {
    logic       irq_ext;  // external irq line
    logic [4:0] irq_id;   // vector index
  } exc_cause_t;

  //////////////////////////////////////////////////
  // datapath bundles
  //////////////////////////////////////////////////

  // branch request into the prefetch block
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;   // word aligned
  } redirect_t;

  // one fetched word as stored in the fetch fifo
  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic [xlen-1:0] addr;
    logic            err;    // bus error on this word
  } fetch_entry_t;

endpackage

// ==== verilog/if_pc_sel.sv ====
// purely combinational; irq vectors need an mtvec base aligned to 256 bytes
`timescale 1ns/100ps

module if_pc_sel import if_pkg::*; #(
  parameter logic [xlen-1:0] dm_halt_addr      = 32'h1A11_0800,
  parameter logic [xlen-1:0] dm_exception_addr = 32'h1A11_0808
) (
  input  logic            pc_set_i,            // redirect this cycle
  input  pc_sel_e         pc_mux_i,            // redirect source
  input  exc_pc_sel_e     exc_pc_mux_i,        // exception target kind
  input  exc_cause_t      exc_cause_i,         // irq vector select
  input  logic [xlen-1:0] boot_addr_i,
  input  logic [xlen-1:0] branch_target_ex_i,  // jump / branch target from ex
  input  logic [xlen-1:0] csr_mepc_i,
  input  logic [xlen-1:0] csr_depc_i,
  input  logic [xlen-1:0] csr_mtvec_i,
  output redirect_t       redirect_o,          // to prefetch
  output logic            csr_mtvec_init_o     // csr file loads mtvec from boot addr
);

  logic [xlen-1:0] mtvec_base;
  logic [xlen-1:0] boot_pc;
  logic [xlen-1:0] exc_pc;
  logic [xlen-1:0] next_pc;

  assign mtvec_base = {csr_mtvec_i[xlen-1:8], 8'h00};  // mode bits and low offset dropped
  assign boot_pc    = {boot_addr_i[xlen-1:8], 8'h00} + boot_offset;

  // exception target
  // external irqs come with their own id here, irq_ext only matters to the csr cause
  always_comb begin
    case (exc_pc_mux_i)
      exc_pc_exc:     exc_pc = mtvec_base;
      exc_pc_irq:     exc_pc = mtvec_base + {{(xlen-7){1'b0}}, exc_cause_i.irq_id, 2'b00};
      exc_pc_dbd:     exc_pc = dm_halt_addr;
      exc_pc_dbg_exc: exc_pc = dm_exception_addr;
      default:        exc_pc = mtvec_base;
    endcase
  end

  // redirect source
  always_comb begin
    case (pc_mux_i)
      pc_boot: next_pc = boot_pc;
      pc_jump: next_pc = branch_target_ex_i;
      pc_exc:  next_pc = exc_pc;
      pc_eret: next_pc = csr_mepc_i;   // mret
      pc_dret: next_pc = csr_depc_i;   // dret
      default: next_pc = boot_pc;      // unused encodings
    endcase
  end

  assign redirect_o.valid = pc_set_i;
  assign redirect_o.addr  = {next_pc[xlen-1:2], 2'b00};  // fetch is word based

  // mtvec gets its reset value together with the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == pc_boot);

endmodule

// ==== prefetch/prefetch_ctrl.sv ====
// a redirect issues in its own cycle unless an ungranted request is held or the in-flight limit is hit
`timescale 1ns/100ps

module prefetch_ctrl import if_pkg::*; #(
  parameter int unsigned fifo_depth      = 3,
  parameter int unsigned max_outstanding = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_i,          // fetch enable
  input  redirect_t                         redirect_i,
  output logic                              instr_req_o,
  output logic [xlen-1:0]                   instr_addr_o,
  input  logic                              instr_gnt_i,
  input  logic                              instr_rvalid_i,
  input  logic                              instr_err_i,
  input  logic [xlen-1:0]                   instr_rdata_i,
  input  logic [$clog2(fifo_depth+1)-1:0]   fifo_count_i,   // words waiting in the fifo
  output logic                              push_o,
  output fetch_entry_t                      push_entry_o,
  output logic                              flush_o,
  output logic                              busy_o
);

  localparam int unsigned ptr_w = (max_outstanding > 1) ? $clog2(max_outstanding) : 1;
  localparam int unsigned oc_w  = $clog2(max_outstanding + 1);

  logic [xlen-1:0]            fetch_addr_q;                 // next address to request
  logic                       pend_q;                       // request up, no grant yet
  logic                       pend_stale_q;                 // held request predates a redirect
  logic [xlen-1:0]            pend_addr_q;
  logic [xlen-1:0]            oq_addr_q [max_outstanding];  // in-flight addresses, in order
  logic [max_outstanding-1:0] oq_disc_q;                    // drop the response of this slot
  logic [ptr_w-1:0]           oq_wr_q;
  logic [ptr_w-1:0]           oq_rd_q;
  logic [oc_w-1:0]            oq_cnt_q;
  logic [$clog2(fifo_depth+1)-1:0] fifo_occ;
  logic                       space_ok;
  logic                       gnt_fire;
  logic                       req_stale;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(max_outstanding - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  assign fifo_occ  = redirect_i.valid ? '0 : fifo_count_i;  // flushed this cycle
  assign space_ok  = (oq_cnt_q < oc_w'(max_outstanding)) &&
                     (int'(oq_cnt_q) + int'(fifo_occ) < int'(fifo_depth));

  assign instr_req_o  = pend_q | (req_i & space_ok);       // held request never drops
  assign instr_addr_o = pend_q           ? pend_addr_q    :
                        redirect_i.valid ? redirect_i.addr : fetch_addr_q;
  assign gnt_fire     = instr_req_o & instr_gnt_i;
  assign req_stale    = pend_q & (pend_stale_q | redirect_i.valid);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
    end else if (redirect_i.valid) begin
      // a fresh request granted now already took the target
      fetch_addr_q <= (gnt_fire && !pend_q) ? redirect_i.addr + xlen'(4) : redirect_i.addr;
    end else if (gnt_fire && !req_stale) begin
      fetch_addr_q <= fetch_addr_q + xlen'(4);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q       <= 1'b0;
      pend_stale_q <= 1'b0;
    end else begin
      pend_q       <= instr_req_o & ~instr_gnt_i;
      pend_stale_q <= instr_req_o & ~instr_gnt_i & req_stale;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_req_o && !instr_gnt_i && !pend_q) begin
      pend_addr_q <= instr_addr_o;  // freeze address until grant
    end
  end

  //////////////////////////////////////////////////
  // outstanding queue
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (gnt_fire) begin
      oq_addr_q[oq_wr_q] <= instr_addr_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      oq_disc_q <= '0;
      oq_wr_q   <= '0;
      oq_rd_q   <= '0;
      oq_cnt_q  <= '0;
    end else begin
      if (redirect_i.valid) begin
        oq_disc_q <= '1;                    // everything in flight is now stale
      end
      if (gnt_fire) begin
        oq_disc_q[oq_wr_q] <= req_stale;    // new slot overrides the blanket set
        oq_wr_q            <= ptr_inc(oq_wr_q);
      end
      if (instr_rvalid_i) begin
        oq_rd_q <= ptr_inc(oq_rd_q);
      end
      case ({gnt_fire, instr_rvalid_i})
        2'b10:   oq_cnt_q <= oq_cnt_q + 1'b1;
        2'b01:   oq_cnt_q <= oq_cnt_q - 1'b1;
        default: oq_cnt_q <= oq_cnt_q;
      endcase
    end
  end

  // response side, rvalid in the redirect cycle is old by definition
  assign push_o             = instr_rvalid_i & ~oq_disc_q[oq_rd_q] & ~redirect_i.valid;
  assign push_entry_o.rdata = instr_rdata_i;
  assign push_entry_o.addr  = oq_addr_q[oq_rd_q];
  assign push_entry_o.err   = instr_err_i;
  assign flush_o            = redirect_i.valid;
  assign busy_o             = pend_q | (oq_cnt_q != '0);

endmodule

// ==== prefetch/fetch_fifo.sv ====
// no overflow guard; the prefetch side only issues requests that fit the free slots
`timescale 1ns/100ps

module fetch_fifo import if_pkg::*; #(
  parameter int unsigned fifo_depth = 3
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,   // redirect, drop everything
  input  logic                            push_i,
  input  fetch_entry_t                    push_entry_i,
  input  logic                            ready_i,   // if-id takes the head
  output logic                            valid_o,
  output fetch_entry_t                    entry_o,
  output logic [$clog2(fifo_depth+1)-1:0] count_o
);

  localparam int unsigned ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int unsigned cnt_w = $clog2(fifo_depth + 1);

  fetch_entry_t     mem_q [fifo_depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             pop;

  function automatic logic [ptr_w-1:0] wrap_inc(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign valid_o = (count_q != '0);    // empty when count is zero
  assign entry_o = mem_q[rd_ptr_q];    // head, registered storage
  assign pop     = valid_o & ready_i;
  assign count_o = count_q;

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  //////////////////////////////////////////////////
  // pointers and fill level
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;   // whole contents lost
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wrap_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= wrap_inc(rd_ptr_q);
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // idle or push with pop
      endcase
    end
  end

endmodule

// ==== verilog/if_id_reg.sv ====
// valid holds until the id stage clears it; payload flops only load on a capture
`timescale 1ns/100ps

module if_id_reg import if_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            fetch_valid_i,        // fifo head present
  input  fetch_entry_t    fetch_entry_i,
  input  logic            id_in_ready_i,
  input  logic            pc_set_i,             // redirect squashes the incoming word
  input  logic            instr_valid_clear_i,
  output logic            fetch_ready_o,
  output logic            instr_valid_id_o,
  output logic            instr_new_id_o,       // one cycle after each capture
  output logic [xlen-1:0] instr_rdata_id_o,
  output logic [xlen-1:0] pc_id_o,
  output logic            instr_fetch_err_o
);

  logic capture;

  assign fetch_ready_o = id_in_ready_i & ~pc_set_i;
  assign capture       = fetch_valid_i & fetch_ready_o;

  // control flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= capture | (instr_valid_id_o & ~instr_valid_clear_i);
      instr_new_id_o   <= capture;
    end
  end

  // frozen while id stalls
  always_ff @(posedge clk_i) begin
    if (capture) begin
      instr_rdata_id_o  <= fetch_entry_i.rdata;
      pc_id_o           <= fetch_entry_i.addr;
      instr_fetch_err_o <= fetch_entry_i.err;
    end
  end

endmodule

// ==== verilog/if_stage.sv ====
// fetch stage top; no icache, no branch prediction, 32 bit aligned instructions only
`timescale 1ns/100ps

module if_stage import if_pkg::*; #(
  parameter logic [xlen-1:0] dm_halt_addr      = 32'h1A11_0800,
  parameter logic [xlen-1:0] dm_exception_addr = 32'h1A11_0808,
  parameter int unsigned     fifo_depth        = 3,
  parameter int unsigned     max_outstanding   = 2
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,               // fetch enable
  input  logic [xlen-1:0] boot_addr_i,
  // instruction bus
  output logic            instr_req_o,
  output logic [xlen-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [xlen-1:0] instr_rdata_i,
  input  logic            instr_err_i,
  // redirect and csr
  input  logic            pc_set_i,
  input  pc_sel_e         pc_mux_i,
  input  exc_pc_sel_e     exc_pc_mux_i,
  input  exc_cause_t      exc_cause_i,
  input  logic [xlen-1:0] branch_target_ex_i,
  input  logic [xlen-1:0] csr_mepc_i,
  input  logic [xlen-1:0] csr_depc_i,
  input  logic [xlen-1:0] csr_mtvec_i,
  output logic            csr_mtvec_init_o,
  // id side
  input  logic            id_in_ready_i,
  input  logic            instr_valid_clear_i,
  output logic            if_busy_o,
  output logic [xlen-1:0] pc_if_o,             // fifo head address
  output logic            instr_valid_id_o,
  output logic            instr_new_id_o,
  output logic [xlen-1:0] instr_rdata_id_o,
  output logic [xlen-1:0] pc_id_o,
  output logic            instr_fetch_err_o
);

  redirect_t                       redirect;
  logic                            push;
  fetch_entry_t                    push_entry;
  logic                            flush;
  logic                            fifo_valid;
  fetch_entry_t                    fifo_entry;
  logic [$clog2(fifo_depth+1)-1:0] fifo_count;
  logic                            fetch_ready;

  if_pc_sel #(
    .dm_halt_addr      (dm_halt_addr),
    .dm_exception_addr (dm_exception_addr)
  ) u_pc_sel (
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .exc_cause_i        (exc_cause_i),
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .redirect_o         (redirect),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  //////////////////////////////////////////////////
  // prefetch: bus side and word buffer
  //////////////////////////////////////////////////

  prefetch_ctrl #(
    .fifo_depth      (fifo_depth),
    .max_outstanding (max_outstanding)
  ) u_prefetch_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .redirect_i     (redirect),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_err_i    (instr_err_i),
    .instr_rdata_i  (instr_rdata_i),
    .fifo_count_i   (fifo_count),
    .push_o         (push),
    .push_entry_o   (push_entry),
    .flush_o        (flush),
    .busy_o         (if_busy_o)
  );

  fetch_fifo #(
    .fifo_depth (fifo_depth)
  ) u_fetch_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush),
    .push_i       (push),
    .push_entry_i (push_entry),
    .ready_i      (fetch_ready),
    .valid_o      (fifo_valid),
    .entry_o      (fifo_entry),
    .count_o      (fifo_count)
  );

  assign pc_if_o = fifo_entry.addr;

  if_id_reg u_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fifo_valid),
    .fetch_entry_i       (fifo_entry),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .pc_id_o             (pc_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o)
  );

endmodule

// ==== sim/if_stage_assert.sv ====
// bound into if_stage; in-flight count tracks every grant against one rvalid each
`timescale 1ns/100ps

module if_stage_assert import if_pkg::*; #(
  parameter int unsigned max_outstanding = 2
) (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            pc_set_i,
  input logic            instr_req_o,
  input logic [xlen-1:0] instr_addr_o,
  input logic            instr_gnt_i,
  input logic            instr_rvalid_i,
  input logic            instr_valid_id_o,
  input logic            instr_new_id_o
);

  logic [3:0] in_flight_q;  // granted minus answered

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight_q <= '0;
    end else begin
      in_flight_q <= in_flight_q + 4'(instr_req_o & instr_gnt_i) - 4'(instr_rvalid_i);
    end
  end

  // held request keeps address
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instr_req_o or instr_addr_o changed before grant");

  a_max_out: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_flight_q <= 4'(max_outstanding))
    else $error("more requests outstanding than allowed");

  // no word reaches id out of the redirect cycle
  a_new_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_valid_id_o && !$past(pc_set_i))
    else $error("instr_new_id_o without instr_valid_id_o or right after a redirect");

endmodule

// ==== sim/tb_if_stage.sv ====
// single thread drives bus, id side and redirects on the falling edge; memory answers in order
`timescale 1ns/100ps

module tb_if_stage import if_pkg::*; ();

  localparam logic [xlen-1:0] halt_addr  = 32'h1A11_0800;
  localparam logic [xlen-1:0] dexc_addr  = 32'h1A11_0808;
  localparam logic [xlen-1:0] mem_xor    = 32'h5a5a_0000;  // data = address ^ this
  localparam logic [xlen-1:0] err_addr   = 32'h0000_4008;  // the one bus error word
  localparam int              row_limit  = 300;            // cycles per row before timeout
  localparam int              n_rows     = 11;

  // one redirect scenario
  typedef struct packed {
    pc_sel_e         pc_mux;
    exc_pc_sel_e     exc_mux;
    logic [4:0]      irq_id;
    logic [xlen-1:0] target;   // jump target, mepc and depc
    logic [7:0]      n_instr;  // words to accept
    logic            stall;    // random id stalls
    logic [xlen-1:0] exp_pc;   // first pc_id_o
  } row_t;

  // boot base 0x1000 and mtvec base 0x2000
  localparam row_t stim_table [n_rows] = '{
    '{pc_boot, exc_pc_exc,     5'd0,  32'h0,         8'd4, 1'b0, 32'h0000_1080},
    '{pc_jump, exc_pc_exc,     5'd0,  32'h0000_4000, 8'd6, 1'b0, 32'h0000_4000},
    '{pc_exc,  exc_pc_exc,     5'd0,  32'h0,         8'd3, 1'b0, 32'h0000_2000},
    '{pc_exc,  exc_pc_irq,     5'd5,  32'h0,         8'd3, 1'b0, 32'h0000_2014},
    '{pc_exc,  exc_pc_dbd,     5'd0,  32'h0,         8'd2, 1'b0, 32'h1A11_0800},
    '{pc_exc,  exc_pc_dbg_exc, 5'd0,  32'h0,         8'd2, 1'b0, 32'h1A11_0808},
    '{pc_eret, exc_pc_exc,     5'd0,  32'h0000_3002, 8'd5, 1'b1, 32'h0000_3000},
    '{pc_dret, exc_pc_exc,     5'd0,  32'h0000_5004, 8'd3, 1'b0, 32'h0000_5004},
    '{pc_jump, exc_pc_exc,     5'd0,  32'h0000_6000, 8'd1, 1'b0, 32'h0000_6000},  // short
    '{pc_jump, exc_pc_exc,     5'd0,  32'h0000_4000, 8'd8, 1'b1, 32'h0000_4000},
    '{pc_exc,  exc_pc_irq,     5'd31, 32'h0,         8'd2, 1'b1, 32'h0000_207C}
  };

  logic clk_i = 1'b0;
  logic rst_ni, req_i, pc_set_i, csr_mtvec_init_o, id_in_ready_i, instr_valid_clear_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i, if_busy_o;
  logic instr_valid_id_o, instr_new_id_o, instr_fetch_err_o;
  logic [xlen-1:0] boot_addr_i, instr_addr_o, instr_rdata_i, branch_target_ex_i;
  logic [xlen-1:0] csr_mepc_i, csr_depc_i, csr_mtvec_i, pc_if_o, instr_rdata_id_o, pc_id_o;
  pc_sel_e         pc_mux_i;
  exc_pc_sel_e     exc_pc_mux_i;
  exc_cause_t      exc_cause_i;

  logic [xlen-1:0] addr_q [$];   // granted, not yet answered
  logic [xlen-1:0] got_pc [$];   // words seen at id
  logic [xlen-1:0] got_head [$]; // fifo head pc at each capture
  logic [xlen-1:0] got_rdata [$];
  logic            got_err [$];
  int gnt_wait, rsp_wait, stall_left, n_checks, n_errors;
  logic stall_on, timed_out;

  always #5 clk_i = ~clk_i;

  if_stage #(
    .dm_halt_addr (halt_addr), .dm_exception_addr (dexc_addr),
    .fifo_depth (3), .max_outstanding (2)
  ) u_if_stage (.*);

  bind if_stage if_stage_assert #(.max_outstanding (max_outstanding)) u_if_stage_assert (.*);

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic expect_word(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // sample the coming handshake then drive memory and id side at the falling edge
  task automatic bus_cycle();
    logic [xlen-1:0] rsp_addr;
    logic [xlen-1:0] head_pc;
    #1;  // inputs of this cycle settled
    head_pc = pc_if_o;  // word that a capture at the coming edge takes
    if (instr_req_o && instr_gnt_i) begin
      addr_q.push_back(instr_addr_o);
      gnt_wait = $urandom % 4;
    end
    @(negedge clk_i);
    pc_set_i       = 1'b0;
    instr_rvalid_i = 1'b0;
    if (addr_q.size() > 0) begin
      if (rsp_wait == 0) begin
        rsp_addr       = addr_q.pop_front();  // in order
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = rsp_addr ^ mem_xor;
        instr_err_i    = (rsp_addr == err_addr);
        rsp_wait       = $urandom % 4;
      end else begin
        rsp_wait--;
      end
    end
    instr_gnt_i = (gnt_wait == 0);
    if (gnt_wait != 0) gnt_wait--;
    // id model sees stable registered outputs here
    if (instr_new_id_o) begin
      got_pc.push_back(pc_id_o);
      got_head.push_back(head_pc);
      got_rdata.push_back(instr_rdata_id_o);
      got_err.push_back(instr_fetch_err_o);
    end
    instr_valid_clear_i = instr_valid_id_o;  // consume right away
    if (stall_on && stall_left != 0) begin
      id_in_ready_i = 1'b0;
      stall_left--;
    end else begin
      id_in_ready_i = 1'b1;
      if (stall_on && ($urandom % 3 == 0)) stall_left = 1 + $urandom % 5;
    end
  endtask

  task automatic apply_row(input int r, input row_t row);
    logic [xlen-1:0] exp_pc;
    int wait_cnt;
    bus_cycle();
    pc_mux_i = row.pc_mux;
    exc_pc_mux_i = row.exc_mux;
    exc_cause_i = exc_cause_t'({1'b1, row.irq_id});
    branch_target_ex_i = row.target;
    csr_mepc_i = row.target;
    csr_depc_i = row.target;
    stall_on = row.stall;
    req_i = 1'b1;
    pc_set_i = 1'b1;
    got_pc.delete();  // anything older is pre-redirect
    got_head.delete();
    got_rdata.delete();
    got_err.delete();
    #1 check_flag("csr_mtvec_init_o", csr_mtvec_init_o, row.pc_mux == pc_boot);
    wait_cnt = 0;
    while (got_pc.size() < int'(row.n_instr) && wait_cnt < row_limit) begin
      bus_cycle();
      wait_cnt++;
    end
    if (got_pc.size() < int'(row.n_instr)) begin
      $display("timeout in row %0d: only %0d of %0d instructions reached decode",
               r, got_pc.size(), row.n_instr);
      timed_out = 1'b1;
    end else begin
      for (int i = 0; i < int'(row.n_instr); i++) begin
        exp_pc = row.exp_pc + xlen'(4 * i);  // sequential after the target
        expect_word("pc_id_o", got_pc[i], exp_pc);
        expect_word("pc_if_o", got_head[i], exp_pc);
        expect_word("instr_rdata_id_o", got_rdata[i], exp_pc ^ mem_xor);
        check_flag("instr_fetch_err_o", got_err[i], exp_pc == err_addr);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int drain;
    void'($urandom(32'ha262_914a));
    {rst_ni, req_i, pc_set_i, instr_gnt_i, instr_rvalid_i, instr_err_i} = '0;
    {instr_valid_clear_i, stall_on, timed_out} = '0;
    id_in_ready_i = 1'b1;
    pc_mux_i = pc_boot;
    exc_pc_mux_i = exc_pc_exc;
    exc_cause_i = '0;
    boot_addr_i = 32'h0000_1000;
    csr_mtvec_i = 32'h0000_2001;  // vectored mode bit set
    {instr_rdata_i, branch_target_ex_i, csr_mepc_i, csr_depc_i} = '0;
    {gnt_wait, rsp_wait, stall_left, n_checks, n_errors} = '0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("instr_req_o", instr_req_o, 1'b0);
    check_flag("instr_valid_id_o", instr_valid_id_o, 1'b0);
    check_flag("instr_new_id_o", instr_new_id_o, 1'b0);
    check_flag("csr_mtvec_init_o", csr_mtvec_init_o, 1'b0);
    check_flag("if_busy_o", if_busy_o, 1'b0);
    for (int r = 0; r < n_rows && !timed_out; r++) begin
      apply_row(r, stim_table[r]);
    end
    req_i = 1'b0;  // let the bus drain
    stall_on = 1'b0;
    drain = 0;
    while (if_busy_o && drain < row_limit && !timed_out) begin
      bus_cycle();
      drain++;
    end
    if (if_busy_o && !timed_out) begin
      $display("timeout: fetch stage still busy after fetch was disabled");
      timed_out = 1'b1;
    end
    $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, timed_out);
    if (n_errors == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
common/if_pkg.sv
verilog/if_pc_sel.sv
prefetch/prefetch_ctrl.sv
prefetch/fetch_fifo.sv
verilog/if_id_reg.sv
verilog/if_stage.sv
sim/if_stage_assert.sv
sim/tb_if_stage.sv

// ==== Bender.yml ====
package:
  name: if_stage

sources:
  - common/if_pkg.sv
  - verilog/if_pc_sel.sv
  - prefetch/prefetch_ctrl.sv
  - prefetch/fetch_fifo.sv
  - verilog/if_id_reg.sv
  - verilog/if_stage.sv
  - target: simulation
    files:
      - sim/if_stage_assert.sv
      - sim/tb_if_stage.sv
